/* verilog/nes_bus_pkg.sv */
////////////////////////////////////////
// CPU side and system bus definitions
// Shared by the DMA stages and the testbench
// Holds the fixed DMA related port addresses
////////////////////////////////////////

package nes_bus_pkg;

	// Basic bus words
	typedef logic [15:0] bus_addr_t;   // 6502 address space
	typedef logic [7:0]  bus_data_t;   // One data byte

	// Outputs of the CPU core itself, before any DMA takeover
	typedef struct packed {
		bus_addr_t addr;   // Address driven by the CPU
		bus_data_t dout;   // Write data from the CPU
		logic      rnw;    // 1 = read cycle
	} cpu_bus_t;

	// Outgoing system bus after the DMA/CPU mux
	// Exactly one of read and write is high in every cycle
	typedef struct packed {
		bus_addr_t addr;   // Post-mux address
		bus_data_t data;   // Post-mux write data
		logic      read;   // Read strobe
		logic      write;  // Write strobe
	} sys_bus_t;

	// Writing a page number here starts the sprite DMA
	localparam bus_addr_t SPRITE_DMA_PORT = 16'h4014;

	// PPU OAM data register, target of every sprite DMA write
	localparam bus_addr_t OAM_DATA_PORT = 16'h2004;

endpackage

/* verilog/nes_dma_pkg.sv */
////////////////////////////////////////
// DMA engine definitions
// State encodings and the structs that pass
// between decode, sequencer and bus mux
////////////////////////////////////////

package nes_dma_pkg;

	// Sprite DMA state
	// Bit 0 pauses the CPU, bit 1 means a transfer owns the bus
	typedef enum logic [1:0] {
		SPR_IDLE  = 2'b00,  // Nothing pending
		SPR_ALIGN = 2'b01,  // Waiting for an odd CPU read cycle
		SPR_XFER  = 2'b11   // Moving bytes, read even / write odd
	} spr_state_t;

	// DMC sample fetch channel
	typedef enum logic {
		DMC_IDLE  = 1'b0,
		DMC_FETCH = 1'b1    // Fetch granted, runs on next even cycle
	} dmc_state_t;

	// One full page per sprite DMA
	localparam int PAGE_BYTES = 256;

	// Decode to sequencer, already qualified
	typedef struct packed {
		logic                  spr_start;  // Port write seen this cycle
		nes_bus_pkg::bus_data_t spr_page;  // High byte of the source page
		logic                  dmc_go;     // DMC fetch may start
	} dma_req_t;

	// Sequencer registers, seen by the mux
	typedef struct packed {
		spr_state_t            spr_state;
		logic                  dmc_fetch;  // DMC channel busy
		logic                  odd_cycle;  // 1 on odd CPU cycles
		nes_bus_pkg::bus_addr_t spr_addr;  // Current sprite source address
		nes_bus_pkg::bus_data_t last_val;  // Byte read on the even cycle
	} dma_ctl_t;

endpackage

/* verilog/dma_port_decode.sv */
////////////////////////////////////////
// DMA decode stage
// Spots the sprite DMA port write on the
// outgoing bus and qualifies DMC requests
////////////////////////////////////////

`timescale 1ns/1ps

module dma_port_decode (
	input  nes_bus_pkg::sys_bus_t bus,          // Post-mux system bus
	input  logic                  dmc_trigger,  // DMC wants a sample byte
	input  logic                  odd_cycle,    // Current cycle parity
	input  logic                  dmc_busy,     // DMC fetch already granted
	output nes_dma_pkg::dma_req_t req
);

	import nes_bus_pkg::*;

	logic port_hit;   // Address matches the sprite DMA port
	logic spr_write;  // Qualified port write
	logic even_read;  // Read on an even cycle
	logic dmc_ok;

	// Compare against the post-mux address, like the real chip does
	assign port_hit  = (bus.addr == SPRITE_DMA_PORT);
	assign spr_write = port_hit && bus.write;

	// DMC may only start on an even read cycle
	assign even_read = bus.read && !odd_cycle;
	assign dmc_ok    = dmc_trigger && even_read && !dmc_busy;  // One fetch at a time

	always_comb begin
		req.spr_start = spr_write;
		req.spr_page  = bus.data;  // Page byte rides on the write data
		req.dmc_go    = dmc_ok;
	end

endmodule

/* verilog/dma_sequencer.sv */
////////////////////////////////////////
// DMA execute stage
// Even/odd flag, sprite and DMC state,
// page address counter and byte latch
// All state advances only when ce is high
////////////////////////////////////////

`timescale 1ns/1ps

module dma_sequencer (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   ce,        // CPU cycle enable
	input  nes_dma_pkg::dma_req_t  req,       // Qualified requests from decode
	input  logic                   cpu_read,  // CPU is in a read cycle
	input  nes_bus_pkg::bus_data_t ram_data,  // Data returned for current address
	output nes_dma_pkg::dma_ctl_t  ctl
);

	import nes_bus_pkg::*;
	import nes_dma_pkg::*;

	spr_state_t spr_state;
	dmc_state_t dmc_state;
	logic       odd_cycle;
	bus_addr_t  spr_addr;
	bus_data_t  last_val;

	bus_data_t  next_low;    // Low address byte plus one
	logic       xfer;        // Sprite transfer owns the bus
	logic       last_byte;   // Final byte of the page
	logic       dmc_now;     // DMC fetch takes this even cycle
	logic       align_done;

	assign xfer      = spr_state[1];
	assign next_low  = spr_addr[7:0] + 8'h01;
	assign last_byte = (spr_addr[7:0] == 8'(PAGE_BYTES - 1));
	assign dmc_now   = (dmc_state == DMC_FETCH) && !odd_cycle;

	// Transfer may start once the CPU sits in an odd read cycle
	assign align_done = (spr_state == SPR_ALIGN) && cpu_read && odd_cycle;

	// Parity flag flips on every CPU cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			odd_cycle <= 1'b0;  // First cycle after reset is even
		end else if (ce) begin
			odd_cycle <= ~odd_cycle;
		end
	end

	// DMC channel
	always_ff @(posedge clk) begin
		if (reset) begin
			dmc_state <= DMC_IDLE;
		end else if (ce) begin
			if (req.dmc_go)
				dmc_state <= DMC_FETCH;  // Decode already checked idle and even
			else if (dmc_now)
				dmc_state <= DMC_IDLE;   // Single byte done
		end
	end

	// Sprite FSM
	// Highest priority first
	always_ff @(posedge clk) begin
		if (reset) begin
			spr_state <= SPR_IDLE;
		end else if (ce) begin
			if (xfer && odd_cycle && last_byte)
				spr_state <= SPR_IDLE;   // Wrap from FF ends the page
			else if (xfer && dmc_now)
				spr_state <= SPR_ALIGN;  // DMC steals the read slot
			else if (align_done)
				spr_state <= SPR_XFER;
			else if (req.spr_start)
				spr_state <= SPR_ALIGN;  // Pause CPU, wait for alignment
		end
	end

	// Source address
	// Only the low byte counts up
	always_ff @(posedge clk) begin
		if (ce) begin
			if (req.spr_start)
				spr_addr <= {req.spr_page, 8'h00};
			else if (xfer && odd_cycle)
				spr_addr[7:0] <= next_low;  // Step after each OAM write
		end
	end

	// Byte latch between the read and the write
	always_ff @(posedge clk) begin
		if (ce && xfer)
			last_val <= ram_data;
	end

	assign ctl = '{
		spr_state: spr_state,
		dmc_fetch: (dmc_state == DMC_FETCH),
		odd_cycle: odd_cycle,
		spr_addr:  spr_addr,
		last_val:  last_val
	};

endmodule

/* verilog/dma_bus_mux.sv */
////////////////////////////////////////
// DMA result stage
// Builds the DMA bus cycle, picks DMA or CPU
// for the outgoing bus, drives ack and pause
////////////////////////////////////////

`timescale 1ns/1ps

module dma_bus_mux (
	input  nes_dma_pkg::dma_ctl_t  ctl,          // Sequencer registers
	input  nes_bus_pkg::cpu_bus_t  cpu,          // CPU core outputs
	input  logic                   dmc_trigger,  // Raw DMC request level
	input  nes_bus_pkg::bus_addr_t dmc_addr,     // DMC sample address
	output nes_bus_pkg::sys_bus_t  bus,
	output logic                   dmc_ack,      // DMC byte is on the bus
	output logic                   pause_cpu
);

	import nes_bus_pkg::*;

	logic      dma_own;   // DMA drives the bus this cycle
	logic      even;
	bus_addr_t dma_addr;

	assign even    = !ctl.odd_cycle;
	assign dmc_ack = ctl.dmc_fetch && even;       // Fetch always lands on even
	assign dma_own = dmc_ack || ctl.spr_state[1];

	// Address priority DMC, sprite read, OAM write
	always_comb begin
		if (dmc_ack)
			dma_addr = dmc_addr;
		else if (even)
			dma_addr = ctl.spr_addr;
		else
			dma_addr = OAM_DATA_PORT;
	end

	always_comb begin
		if (dma_own) begin
			bus.addr  = dma_addr;
			bus.data  = ctl.last_val;  // Only meaningful on odd writes
			bus.read  = even;
			bus.write = ctl.odd_cycle;
		end else begin
			bus.addr  = cpu.addr;     // CPU passes straight through
			bus.data  = cpu.dout;
			bus.read  = cpu.rnw;
			bus.write = !cpu.rnw;
		end
	end

	// Trigger stalls the CPU at once, sprite waits for the state bit
	assign pause_cpu = ctl.spr_state[0] || dmc_trigger;

endmodule

/* verilog/nes_dma_top.sv */
////////////////////////////////////////
// Sprite and DMC DMA engine top level
// Sits between the 6502 core and the
// system bus, decode feeds sequencer
// feeds mux, mux output feeds decode
////////////////////////////////////////

`timescale 1ns/1ps

module nes_dma_top (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   ce,           // CPU cycle enable
	input  nes_bus_pkg::cpu_bus_t  cpu,          // CPU core outputs
	input  logic                   dmc_trigger,  // Held until dmc_ack
	input  nes_bus_pkg::bus_addr_t dmc_addr,
	input  nes_bus_pkg::bus_data_t ram_data,     // Read data for bus.addr
	output nes_bus_pkg::sys_bus_t  bus,
	output logic                   dmc_ack,
	output logic                   pause_cpu
);

	import nes_dma_pkg::*;

	dma_req_t req;  // Decode to sequencer
	dma_ctl_t ctl;  // Sequencer to mux

	dma_port_decode dma_port_decode_inst (
		.bus         (bus),
		.dmc_trigger (dmc_trigger),
		.odd_cycle   (ctl.odd_cycle),
		.dmc_busy    (ctl.dmc_fetch),
		.req         (req)
	);

	dma_sequencer dma_sequencer_inst (
		.clk      (clk),
		.reset    (reset),
		.ce       (ce),
		.req      (req),
		.cpu_read (cpu.rnw),  // CPU direction, not the muxed one
		.ram_data (ram_data),
		.ctl      (ctl)
	);

	// Select comes from registers only, so the bus loop back
	// into decode is not combinational
	dma_bus_mux dma_bus_mux_inst (
		.ctl         (ctl),
		.cpu         (cpu),
		.dmc_trigger (dmc_trigger),
		.dmc_addr    (dmc_addr),
		.bus         (bus),
		.dmc_ack     (dmc_ack),
		.pause_cpu   (pause_cpu)
	);

endmodule

/* include/tb_dma_model.svh */
////////////////////////////////////////
// Reference model for the DMA testbench
// Expected RAM contents and the expected
// sprite transfer order, included in tb
////////////////////////////////////////

`ifndef TB_DMA_MODEL_SVH
`define TB_DMA_MODEL_SVH

// RAM contents seen by the DUT, low byte XOR high byte
function automatic nes_bus_pkg::bus_data_t ram_byte(input nes_bus_pkg::bus_addr_t addr);
	return addr[7:0] ^ addr[15:8];
endfunction

// Source address of byte idx in page
function automatic nes_bus_pkg::bus_addr_t spr_read_addr(
	input nes_bus_pkg::bus_data_t page,
	input int                     idx
);
	return {page, 8'(idx)};
endfunction

// Data expected on the OAM write that follows byte idx
function automatic nes_bus_pkg::bus_data_t oam_write_data(
	input nes_bus_pkg::bus_data_t page,
	input int                     idx
);
	return ram_byte(spr_read_addr(page, idx));
endfunction

// Next expected sprite read matches this bus cycle
function automatic bit is_next_spr_read(
	input nes_bus_pkg::sys_bus_t  b,
	input nes_bus_pkg::bus_data_t page,
	input int                     idx
);
	return b.read && idx < nes_dma_pkg::PAGE_BYTES && b.addr == spr_read_addr(page, idx);
endfunction

// Bus cycle is a write to the OAM data port
function automatic bit is_oam_write(input nes_bus_pkg::sys_bus_t b);
	return b.write && b.addr == nes_bus_pkg::OAM_DATA_PORT;
endfunction

`endif

/* verification/tb_nes_dma.sv */
////////////////////////////////////////
// Testbench for the sprite and DMC DMA engine
// Drives CPU cycles on the falling edge and checks
// every ce cycle against the reference model
// Prints one line per test and a closing summary
////////////////////////////////////////

`timescale 1ns/1ps

module tb_nes_dma;

	import nes_bus_pkg::*;
	import nes_dma_pkg::*;

	`include "tb_dma_model.svh"

	localparam int NUM_TESTS   = 5;
	localparam int CYCLE_LIMIT = 4 * (NUM_TESTS * 600);

	logic      clk;
	logic      reset;
	logic      ce;
	cpu_bus_t  cpu;
	logic      dmc_trigger;
	bus_addr_t dmc_addr;
	bus_data_t ram_data;
	sys_bus_t  bus;
	logic      dmc_ack;
	logic      pause_cpu;

	integer    seed;
	int        cycle_count;
	int        errors;
	int        test_count;
	int        pass_count;
	int        ce_phase;      // Position in the fixed ce pattern
	bit        random_ce;     // Random ce gaps instead of the fixed pattern
	logic      trig_req;      // Trigger level applied on the next ce cycle
	bus_addr_t dmc_addr_req;

	// Monitor state
	bit        idle_mode;     // Plain CPU passthrough expected
	bit        dmc_mode;      // Idle DMC fetch test running
	bit        spr_watch;     // Sprite sequence tracking on
	bit        port_seen;     // Port write already on the bus
	bit        want_write;    // Next ce cycle must be the OAM write
	bit        fall_pending;  // Pause must drop on the next ce cycle
	bus_data_t spr_page;
	int        rd_idx;        // Sprite reads seen so far
	int        wr_count;      // OAM writes seen so far
	int        dmc_seen;      // dmc_ack cycles seen
	int        ce_count;
	int        first_read_at;
	int        last_write_at;
	bit        prev_low;      // Last edge had ce low
	sys_bus_t  last_bus;
	logic      last_ack;

	assign ram_data = ram_byte(bus.addr);  // Memory answers in the same cycle

	nes_dma_top nes_dma_top_inst (
		.clk         (clk),
		.reset       (reset),
		.ce          (ce),
		.cpu         (cpu),
		.dmc_trigger (dmc_trigger),
		.dmc_addr    (dmc_addr),
		.ram_data    (ram_data),
		.bus         (bus),
		.dmc_ack     (dmc_ack),
		.pause_cpu   (pause_cpu)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#10 clk = ~clk;  // 20 ns period
		end
	end

	// Bus the CPU alone would produce
	function automatic sys_bus_t cpu_view(input cpu_bus_t c);
		sys_bus_t b;
		b.addr  = c.addr;
		b.data  = c.dout;
		b.read  = c.rnw;
		b.write = !c.rnw;
		return b;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		$display("Error at %0d ns: %s expected %h got %h", $time, name, exp, act);
		errors++;
	endtask

	// All checks of one ce cycle
	task automatic check_cycle();
		if (idle_mode) begin
			if (bus != cpu_view(cpu))
				report_mismatch("bus", cpu_view(cpu), bus);
			if (pause_cpu)
				report_mismatch("pause_cpu", 0, pause_cpu);
			if (dmc_ack)
				report_mismatch("dmc_ack", 0, dmc_ack);
		end
		if (dmc_mode) begin
			if (pause_cpu != dmc_trigger)
				report_mismatch("pause_cpu", dmc_trigger, pause_cpu);
			if (!dmc_ack && bus != cpu_view(cpu))
				report_mismatch("bus", cpu_view(cpu), bus);
		end
		if (fall_pending) begin
			if (pause_cpu != dmc_trigger)
				report_mismatch("pause_cpu", dmc_trigger, pause_cpu);
			fall_pending = 0;
		end
		if (port_seen && wr_count < PAGE_BYTES && !pause_cpu)
			report_mismatch("pause_cpu", 1, pause_cpu);  // Held for the whole transfer
		if (dmc_ack) begin
			dmc_seen++;
			if (!bus.read)
				report_mismatch("bus.read", 1, bus.read);
			if (bus.addr != dmc_addr)
				report_mismatch("bus.addr", dmc_addr, bus.addr);
		end else if (spr_watch) begin
			if (want_write) begin
				want_write = 0;
				if (!bus.write)
					report_mismatch("bus.write", 1, bus.write);
				if (bus.addr != OAM_DATA_PORT)
					report_mismatch("bus.addr", OAM_DATA_PORT, bus.addr);
				if (is_oam_write(bus) && bus.data != oam_write_data(spr_page, rd_idx - 1))
					report_mismatch("bus.data", oam_write_data(spr_page, rd_idx - 1), bus.data);
				wr_count++;  // One write slot per read
				if (wr_count == PAGE_BYTES) begin
					last_write_at = ce_count;
					fall_pending  = 1;
				end
			end else if (is_next_spr_read(bus, spr_page, rd_idx)) begin
				if (rd_idx == 0)
					first_read_at = ce_count;
				rd_idx++;
				want_write = 1;
			end else if (bus.read && bus.addr[15:8] == spr_page) begin
				// Skipped, repeated or extra byte of the page
				report_mismatch("bus.addr", spr_read_addr(spr_page, rd_idx), bus.addr);
			end
		end
		if (spr_watch && bus.write && bus.addr == SPRITE_DMA_PORT)
			port_seen = 1;
	endtask

	// Compare process samples before the edge updates anything
	always @(posedge clk) begin
		if (!reset) begin
			if (!ce) begin
				// Nothing may move across two frozen edges
				if (prev_low && bus != last_bus)
					report_mismatch("bus", last_bus, bus);
				if (prev_low && dmc_ack != last_ack)
					report_mismatch("dmc_ack", last_ack, dmc_ack);
			end else begin
				ce_count++;
				check_cycle();
			end
			prev_low = !ce;
			last_bus = bus;
			last_ack = dmc_ack;
		end
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: run did not finish within %0d clock cycles", CYCLE_LIMIT);
		$display("TB FAILED");
		$finish;
	end

	// One CPU cycle after any ce low cycles
	// Inputs only change together with ce high
	task automatic cpu_cycle(input bus_addr_t addr, input bus_data_t dout, input logic rnw);
		int gaps;
		if (random_ce)
			gaps = $random(seed) & 3;
		else
			gaps = (ce_phase == 2) ? 2 : 0;
		ce_phase = (ce_phase + 1) % 3;
		repeat (gaps) begin
			@(negedge clk);
			ce = 1'b0;
		end
		@(negedge clk);
		ce          = 1'b1;
		cpu.addr    = addr;
		cpu.dout    = dout;
		cpu.rnw     = rnw;
		dmc_trigger = trig_req;
		dmc_addr    = dmc_addr_req;
	endtask

	// CPU read well away from sprite pages and DMC samples
	task automatic cpu_read_cycle();
		bus_addr_t a;
		a = 16'h8000 | (16'($random(seed)) & 16'h3FFF);
		cpu_cycle(a, 8'($random(seed)), 1'b1);
	endtask

	task automatic cpu_random_cycle();
		bus_addr_t a;
		bus_data_t d;
		logic      rnw;
		a   = 16'($random(seed));
		d   = 8'($random(seed));
		rnw = 1'($random(seed));
		if (a == SPRITE_DMA_PORT)
			a = a ^ 16'h0100;  // No accidental sprite DMA
		cpu_cycle(a, d, rnw);
	endtask

	task automatic run_sprite(input bit with_dmc);
		bus_data_t page;
		int        steal_at;
		page         = 8'($random(seed)) & 8'h3F;
		steal_at     = 32 + ($random(seed) & 127);
		dmc_addr_req = 16'hC000 | (16'($random(seed)) & 16'h3FFF);
		cpu_cycle(SPRITE_DMA_PORT, page, 1'b0);
		spr_page     = page;
		rd_idx       = 0;
		wr_count     = 0;
		dmc_seen     = 0;
		want_write   = 0;
		fall_pending = 0;
		port_seen    = 0;
		spr_watch    = 1;
		while (wr_count < PAGE_BYTES || pause_cpu) begin
			if (with_dmc && dmc_seen == 0 && rd_idx >= steal_at)
				trig_req = 1'b1;  // Steal a cycle mid page
			if (dmc_seen != 0)
				trig_req = 1'b0;
			cpu_read_cycle();
		end
		repeat (3) cpu_read_cycle();
		spr_watch = 0;
		if (rd_idx != PAGE_BYTES)
			report_mismatch("sprite read count", PAGE_BYTES, rd_idx);
		if (wr_count != PAGE_BYTES)
			report_mismatch("OAM write count", PAGE_BYTES, wr_count);
		if (dmc_seen != int'(with_dmc))
			report_mismatch("dmc_ack count", with_dmc, dmc_seen);
		if (!with_dmc && last_write_at - first_read_at + 1 != 2 * PAGE_BYTES)
			report_mismatch("transfer length", 2 * PAGE_BYTES, last_write_at - first_read_at + 1);
	endtask

	task automatic test_done(input string name, input int err_mark);
		test_count++;
		if (errors == err_mark) begin
			pass_count++;
			$display("Test %0d %s: ok", test_count, name);
		end else begin
			$display("Test %0d %s: %0d errors", test_count, name, errors - err_mark);
		end
	endtask

	initial begin
		int err_mark;
		seed         = 32'hae4f_da93;
		reset        = 1'b1;
		ce           = 1'b0;
		cpu          = '0;
		cpu.rnw      = 1'b1;
		dmc_trigger  = 1'b0;
		dmc_addr     = '0;
		trig_req     = 1'b0;
		dmc_addr_req = '0;
		errors       = 0;
		test_count   = 0;
		pass_count   = 0;
		ce_phase     = 0;
		random_ce    = 0;
		idle_mode    = 0;
		dmc_mode     = 0;
		spr_watch    = 0;
		port_seen    = 0;
		want_write   = 0;
		fall_pending = 0;
		ce_count     = 0;
		prev_low     = 0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		err_mark = errors;
		cpu_random_cycle();
		idle_mode = 1;
		repeat (48) cpu_random_cycle();
		idle_mode = 0;
		test_done("cpu passthrough", err_mark);

		err_mark = errors;
		run_sprite(1'b0);
		test_done("sprite dma", err_mark);

		// Single DMC fetch with the sprite engine idle
		err_mark     = errors;
		dmc_addr_req = 16'hC000 | (16'($random(seed)) & 16'h3FFF);
		trig_req     = 1'b1;
		dmc_seen     = 0;
		cpu_read_cycle();
		dmc_mode = 1;
		while (dmc_seen == 0)
			cpu_read_cycle();
		trig_req = 1'b0;
		repeat (8) cpu_read_cycle();
		dmc_mode = 0;
		if (dmc_seen != 1)
			report_mismatch("dmc_ack count", 1, dmc_seen);
		test_done("dmc fetch idle", err_mark);

		err_mark = errors;
		run_sprite(1'b1);
		test_done("dmc during sprite", err_mark);

		err_mark  = errors;
		random_ce = 1;
		run_sprite(1'b0);
		random_ce = 0;
		test_done("ce stalls", err_mark);

		$display("Summary: %0d tests, %0d ok, %0d errors", test_count, pass_count, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

/* nes_dma.f */
+incdir+include
verilog/nes_bus_pkg.sv
verilog/nes_dma_pkg.sv
verilog/dma_port_decode.sv
verilog/dma_sequencer.sv
verilog/dma_bus_mux.sv
verilog/nes_dma_top.sv
verification/tb_nes_dma.sv
